/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data and address width
`define CORE_XLEN 32

// General registers, r0 is hardwired to zero
`define CORE_REG_COUNT 32

// Byte address of the first fetch
`define CORE_RESET_PC 32'h0000_0000

// Fetch and data masters share the bus
`define CORE_MASTERS 2

`endif

/* verilog/bus_pkg.sv */
`include "core_consts.svh"

package bus_pkg;

    ////////////////////////////////////////
    // Bus payload types
    ////////////////////////////////////////

    // One data word on the bus
    typedef logic [`CORE_XLEN-1:0] word_t;

    // Byte address, word aligned
    typedef logic [`CORE_XLEN-1:0] addr_t;

    // Which master owns the bus
    typedef enum logic [$clog2(`CORE_MASTERS)-1:0] {
        MASTER_FETCH = 1'b0,
        MASTER_DATA  = 1'b1
    } master_t;

endpackage

/* verilog/isa_pkg.sv */
`include "core_consts.svh"

package isa_pkg;

    ////////////////////////////////////////
    // Opcode field, instr[31:26]
    ////////////////////////////////////////

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // Function field of SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        // Immediate placed in the upper half
        ALU_LUI = 4'd5
    } alu_op_t;

    typedef logic [4:0] reg_addr_t;

    typedef struct packed {
        alu_op_t               alu_op;
        reg_addr_t             rs;
        reg_addr_t             rt;
        reg_addr_t             rd;
        logic [`CORE_XLEN-1:0] imm;
        logic                  reg_write;
        logic                  use_imm;
        logic                  load;
        logic                  store;
        logic                  branch_eq;
        logic                  branch_ne;
        logic                  jump;
        logic [25:0]           jidx;
    } decoded_t;

endpackage

/* verilog/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic           clk,
    input  logic           rst_n,
    // Master 0, instruction fetch
    input  logic           m0_cyc,
    input  logic           m0_stb,
    input  logic           m0_we,
    input  bus_pkg::addr_t m0_adr,
    input  bus_pkg::word_t m0_dat_w,
    output bus_pkg::word_t m0_dat_r,
    output logic           m0_ack,
    // Master 1, load and store
    input  logic           m1_cyc,
    input  logic           m1_stb,
    input  logic           m1_we,
    input  bus_pkg::addr_t m1_adr,
    input  bus_pkg::word_t m1_dat_w,
    output bus_pkg::word_t m1_dat_r,
    output logic           m1_ack,
    // Shared Wishbone bus
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output bus_pkg::addr_t wb_adr,
    output bus_pkg::word_t wb_dat_w,
    input  bus_pkg::word_t wb_dat_r,
    input  logic           wb_ack
);

    bus_pkg::master_t grant_q;
    bus_pkg::master_t sel;
    logic             locked;
    logic             hold;

    // Owner from last cycle still in its bus cycle
    assign hold = locked && ((grant_q == bus_pkg::MASTER_DATA) ? m1_cyc : m0_cyc);

    // Data master wins a tie at an idle bus
    always_comb begin
        if (hold) begin
            sel = grant_q;
        end else if (m1_cyc) begin
            sel = bus_pkg::MASTER_DATA;
        end else begin
            sel = bus_pkg::MASTER_FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q <= bus_pkg::MASTER_FETCH;
            locked  <= 1'b0;
        end else begin
            grant_q <= sel;
            locked  <= wb_cyc;
        end
    end

    ////////////////////////////////////////
    // Request mux, no added latency
    ////////////////////////////////////////

    always_comb begin
        if (sel == bus_pkg::MASTER_DATA) begin
            wb_cyc   = m1_cyc;
            wb_stb   = m1_stb;
            wb_we    = m1_we;
            wb_adr   = m1_adr;
            wb_dat_w = m1_dat_w;
        end else begin
            wb_cyc   = m0_cyc;
            wb_stb   = m0_stb;
            wb_we    = m0_we;
            wb_adr   = m0_adr;
            wb_dat_w = m0_dat_w;
        end
    end

    // Response only reaches the owner
    assign m0_ack   = wb_ack && (sel == bus_pkg::MASTER_FETCH);
    assign m1_ack   = wb_ack && (sel == bus_pkg::MASTER_DATA);
    assign m0_dat_r = (sel == bus_pkg::MASTER_FETCH) ? wb_dat_r : '0;
    assign m1_dat_r = (sel == bus_pkg::MASTER_DATA) ? wb_dat_r : '0;

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_unit (
    input  logic           clk,
    input  logic           rst_n,
    // Wishbone master, read only
    output logic           cyc,
    output logic           stb,
    output logic           we,
    output bus_pkg::addr_t adr,
    output bus_pkg::word_t dat_w,
    input  bus_pkg::word_t dat_r,
    input  logic           ack,
    // Instruction buffer towards execute
    output logic           instr_valid,
    output bus_pkg::word_t instr,
    output bus_pkg::addr_t instr_pc,
    input  logic           instr_take,
    input  logic           redirect,
    input  bus_pkg::addr_t redirect_pc
);

    // Address of the next word to fetch
    bus_pkg::addr_t pc;
    // Address on the bus, stable for the whole cycle
    bus_pkg::addr_t fetch_adr;
    logic           fetch_busy;
    // Fetch in flight made stale by a redirect
    logic           discard;

    logic           buf_valid;
    bus_pkg::word_t buf_instr;
    bus_pkg::addr_t buf_pc;

    logic           fetch_done;
    logic           keep_word;
    logic           start_fetch;

    assign fetch_done  = fetch_busy && ack;
    assign keep_word   = fetch_done && !discard && !redirect;
    // Buffer empty or about to be emptied
    assign start_fetch = !fetch_busy && (!buf_valid || instr_take || redirect);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= `CORE_RESET_PC;
            fetch_busy <= 1'b0;
            discard    <= 1'b0;
            buf_valid  <= 1'b0;
        end else begin
            // Bus cycle control
            if (start_fetch) begin
                fetch_busy <= 1'b1;
            end else if (fetch_done) begin
                fetch_busy <= 1'b0;
            end

            if (fetch_done) begin
                discard <= 1'b0;
            end else if (redirect && fetch_busy) begin
                discard <= 1'b1;
            end

            // Next fetch address
            if (redirect) begin
                pc <= redirect_pc;
            end else if (keep_word) begin
                pc <= fetch_adr + bus_pkg::addr_t'(4);
            end

            // Buffer state
            if (redirect) begin
                buf_valid <= 1'b0;
            end else if (keep_word) begin
                buf_valid <= 1'b1;
            end else if (instr_take) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_fetch) begin
            fetch_adr <= redirect ? redirect_pc : pc;
        end
        if (keep_word) begin
            buf_instr <= dat_r;
            buf_pc    <= fetch_adr;
        end
    end

    assign cyc   = fetch_busy;
    assign stb   = fetch_busy;
    assign we    = 1'b0;
    assign adr   = fetch_adr;
    assign dat_w = '0;

    assign instr_valid = buf_valid;
    assign instr       = buf_instr;
    assign instr_pc    = buf_pc;

endmodule

/* verilog/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  bus_pkg::word_t    instr,
    output isa_pkg::decoded_t dec
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    always_comb begin
        // Everything low, unknown encodings fall through as no-ops
        dec        = '0;
        dec.rs     = instr[25:21];
        dec.rt     = instr[20:16];
        dec.jidx   = instr[25:0];
        // Sign extension unless lui
        dec.imm    = {{16{imm16[15]}}, imm16};
        dec.alu_op = isa_pkg::ALU_ADD;

        unique case (opcode)
            isa_pkg::OP_SPECIAL: begin
                // R-type writes rd
                dec.rd        = instr[15:11];
                dec.reg_write = 1'b1;
                unique case (funct)
                    isa_pkg::FN_ADDU: dec.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: dec.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  dec.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   dec.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_SLT:  dec.alu_op = isa_pkg::ALU_SLT;
                    default:          dec.reg_write = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                dec.rd        = instr[20:16];
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                dec.rd        = instr[20:16];
                dec.imm       = {16'h0000, imm16};
                dec.alu_op    = isa_pkg::ALU_LUI;
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
            end
            isa_pkg::OP_LW: begin
                // Address is rs plus offset
                dec.rd      = instr[20:16];
                dec.use_imm = 1'b1;
                dec.load    = 1'b1;
            end
            isa_pkg::OP_SW: begin
                dec.use_imm = 1'b1;
                dec.store   = 1'b1;
            end
            isa_pkg::OP_BEQ: dec.branch_eq = 1'b1;
            isa_pkg::OP_BNE: dec.branch_ne = 1'b1;
            isa_pkg::OP_J:   dec.jump = 1'b1;
            default: begin
                dec.rd = '0;
            end
        endcase
    end

endmodule

/* verilog/execute_unit.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module execute_unit (
    input  logic              clk,
    input  logic              rst_n,
    // From fetch buffer and decoder
    input  logic              instr_valid,
    input  bus_pkg::addr_t    instr_pc,
    input  isa_pkg::decoded_t dec,
    output logic              instr_take,
    output logic              redirect,
    output bus_pkg::addr_t    redirect_pc,
    // Wishbone master for lw and sw
    output logic              cyc,
    output logic              stb,
    output logic              we,
    output bus_pkg::addr_t    adr,
    output bus_pkg::word_t    dat_w,
    input  bus_pkg::word_t    dat_r,
    input  logic              ack
);

    typedef enum logic {
        EX_IDLE,
        EX_BUS
    } ex_state_t;

    ex_state_t          state;
    bus_pkg::word_t     regs [`CORE_REG_COUNT];

    bus_pkg::word_t     rs_val;
    bus_pkg::word_t     rt_val;
    bus_pkg::word_t     op_b;
    bus_pkg::word_t     alu_res;
    logic               equal;
    logic               taken;
    bus_pkg::addr_t     pc_plus4;

    // Held for the length of the memory access
    bus_pkg::addr_t     mem_adr;
    bus_pkg::word_t     mem_dat;
    logic               mem_we;
    isa_pkg::reg_addr_t ld_rd;

    ////////////////////////////////////////
    // Operands and ALU
    ////////////////////////////////////////

    // r0 reads as zero
    assign rs_val = (dec.rs == '0) ? '0 : regs[dec.rs];
    assign rt_val = (dec.rt == '0) ? '0 : regs[dec.rt];
    assign op_b   = dec.use_imm ? dec.imm : rt_val;

    always_comb begin
        unique case (dec.alu_op)
            isa_pkg::ALU_ADD: alu_res = rs_val + op_b;
            isa_pkg::ALU_SUB: alu_res = rs_val - op_b;
            isa_pkg::ALU_AND: alu_res = rs_val & op_b;
            isa_pkg::ALU_OR:  alu_res = rs_val | op_b;
            isa_pkg::ALU_SLT: begin
                alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(rs_val) < $signed(op_b)};
            end
            isa_pkg::ALU_LUI: alu_res = {op_b[15:0], 16'h0000};
            default:          alu_res = '0;
        endcase
    end

    // Branch compare always on the two registers
    assign equal = (rs_val == rt_val);

    ////////////////////////////////////////
    // Retire and control flow
    ////////////////////////////////////////

    assign instr_take = instr_valid && (state == EX_IDLE);

    assign taken    = (dec.branch_eq && equal) || (dec.branch_ne && !equal);
    assign redirect = instr_take && (taken || dec.jump);
    assign pc_plus4 = instr_pc + bus_pkg::addr_t'(4);

    // Jump keeps the region bits of pc + 4
    assign redirect_pc = dec.jump ? {pc_plus4[31:28], dec.jidx, 2'b00}
                                  : pc_plus4 + {dec.imm[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EX_IDLE;
        end else begin
            unique case (state)
                EX_IDLE: begin
                    if (instr_take && (dec.load || dec.store)) begin
                        state <= EX_BUS;
                    end
                end
                EX_BUS: begin
                    // Access done, retire
                    if (ack) begin
                        state <= EX_IDLE;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

    // Latch the request at take
    always_ff @(posedge clk) begin
        if (instr_take) begin
            mem_adr <= alu_res;
            mem_dat <= rt_val;
            mem_we  <= dec.store;
            ld_rd   <= dec.rd;
        end
    end

    // Register file writes, ALU result or load data
    always_ff @(posedge clk) begin
        if (instr_take && dec.reg_write) begin
            regs[dec.rd] <= alu_res;
        end else if ((state == EX_BUS) && ack && !mem_we) begin
            regs[ld_rd] <= dat_r;
        end
    end

    assign cyc   = (state == EX_BUS);
    assign stb   = (state == EX_BUS);
    assign we    = mem_we;
    assign adr   = mem_adr;
    assign dat_w = mem_dat;

endmodule

/* verilog/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic           clk,
    input  logic           rst_n,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output bus_pkg::addr_t wb_adr,
    output bus_pkg::word_t wb_dat_w,
    input  bus_pkg::word_t wb_dat_r,
    input  logic           wb_ack
);

    ////////////////////////////////////////
    // Fetch side
    ////////////////////////////////////////

    logic              if_cyc;
    logic              if_stb;
    logic              if_we;
    bus_pkg::addr_t    if_adr;
    bus_pkg::word_t    if_dat_w;
    bus_pkg::word_t    if_dat_r;
    logic              if_ack;

    logic              instr_valid;
    bus_pkg::word_t    instr;
    bus_pkg::addr_t    instr_pc;
    logic              instr_take;
    logic              redirect;
    bus_pkg::addr_t    redirect_pc;
    isa_pkg::decoded_t dec;

    // Load and store side
    logic              ex_cyc;
    logic              ex_stb;
    logic              ex_we;
    bus_pkg::addr_t    ex_adr;
    bus_pkg::word_t    ex_dat_w;
    bus_pkg::word_t    ex_dat_r;
    logic              ex_ack;

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cyc         (if_cyc),
        .stb         (if_stb),
        .we          (if_we),
        .adr         (if_adr),
        .dat_w       (if_dat_w),
        .dat_r       (if_dat_r),
        .ack         (if_ack),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_take  (instr_take),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    decoder decoder_i (
        .instr (instr),
        .dec   (dec)
    );

    execute_unit execute_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .dec         (dec),
        .instr_take  (instr_take),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .cyc         (ex_cyc),
        .stb         (ex_stb),
        .we          (ex_we),
        .adr         (ex_adr),
        .dat_w       (ex_dat_w),
        .dat_r       (ex_dat_r),
        .ack         (ex_ack)
    );

    // m0 is fetch, m1 is data
    bus_arbiter bus_arbiter_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .m0_cyc   (if_cyc),
        .m0_stb   (if_stb),
        .m0_we    (if_we),
        .m0_adr   (if_adr),
        .m0_dat_w (if_dat_w),
        .m0_dat_r (if_dat_r),
        .m0_ack   (if_ack),
        .m1_cyc   (ex_cyc),
        .m1_stb   (ex_stb),
        .m1_we    (ex_we),
        .m1_adr   (ex_adr),
        .m1_dat_w (ex_dat_w),
        .m1_dat_r (ex_dat_r),
        .m1_ack   (ex_ack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

/* bench/mips_core_assertions.sv */
`timescale 1ns/1ps

module mips_core_assertions (
    input logic           clk,
    input logic           rst_n,
    input logic           wb_cyc,
    input logic           wb_stb,
    input logic           wb_we,
    input bus_pkg::addr_t wb_adr,
    input bus_pkg::word_t wb_dat_w,
    input logic           wb_ack
);

    // Strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb high while wb_cyc is low");

    // Request held until the slave answers
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
        else $error("wb_adr, wb_we or wb_dat_w changed while waiting for wb_ack");

    // Bus idle in the cycle after reset
    idle_after_reset: assert property (@(posedge clk) !rst_n |=> !wb_cyc)
        else $error("wb_cyc high in the cycle after reset");

endmodule

bind mips_core mips_core_assertions mips_core_assertions_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack)
);

/* bench/mips_core_tb.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module mips_core_tb;

    localparam int MEM_WORDS    = 256;
    // Expected store count followed by address and data pairs
    localparam int COUNT_WORD   = 191;
    localparam int LIST_WORD    = 192;
    localparam int DRAIN_CYCLES = 40;
    // Program and preset data live below this byte address
    localparam logic [`CORE_XLEN-1:0] STORE_BASE = 32'h0000_0200;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    bus_pkg::addr_t wb_adr;
    bus_pkg::word_t wb_dat_w;
    bus_pkg::word_t wb_dat_r = '0;
    logic           wb_ack = 1'b0;

    bus_pkg::word_t mem [MEM_WORDS];

    // Memory model state
    logic [31:0]    lfsr = 32'h1db8;
    int             wait_left = 0;
    logic           in_cycle = 1'b0;
    logic           first_seen = 1'b0;

    // Scoreboard
    int             exp_count;
    int             store_idx = 0;
    int             checks = 0;
    int             value_errors = 0;
    int             other_errors = 0;

    always #50 clk = ~clk;

    mips_core mips_core_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // Two fresh bits give 0 to 3 wait states
    task automatic draw_wait(output int n);
        logic [1:0] bits;
        lfsr    = lfsr_next(lfsr);
        bits[0] = lfsr[0];
        lfsr    = lfsr_next(lfsr);
        bits[1] = lfsr[0];
        n       = int'(bits);
    endtask

    task automatic check_value(input string name, input logic [`CORE_XLEN-1:0] expected,
                               input logic [`CORE_XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    // Next store must match the next pair in the list
    task automatic check_store(input bus_pkg::addr_t adr, input bus_pkg::word_t data);
        bus_pkg::word_t exp_adr;
        bus_pkg::word_t exp_dat;
        if (adr < STORE_BASE) begin
            $display("Store of %h to address %h writes into the program region", data, adr);
            other_errors++;
        end
        if (store_idx >= exp_count) begin
            $display("Extra store of %h to address %h after all %0d expected stores",
                     data, adr, exp_count);
            other_errors++;
        end else begin
            exp_adr = mem[8'(LIST_WORD + 2 * store_idx)];
            exp_dat = mem[8'(LIST_WORD + 2 * store_idx + 1)];
            check_value($sformatf("store %0d address", store_idx), exp_adr, adr);
            check_value($sformatf("store %0d data", store_idx), exp_dat, data);
        end
        store_idx++;
    endtask

    ////////////////////////////////////////
    // Wishbone slave memory
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (wb_cyc && wb_stb) begin
            // New request picks its latency
            if (!in_cycle) begin
                draw_wait(wait_left);
                in_cycle = 1'b1;
                if (!first_seen) begin
                    first_seen = 1'b1;
                    check_value("first bus cycle address", `CORE_RESET_PC, wb_adr);
                    check_value("first bus cycle write flag", 32'h0, {31'b0, wb_we});
                end
            end
            if (wait_left == 0) begin
                if (wb_we) begin
                    check_store(wb_adr, wb_dat_w);
                    mem[wb_adr[9:2]] = wb_dat_w;
                end
                wb_dat_r = mem[wb_adr[9:2]];
                wb_ack   = 1'b1;
                in_cycle = 1'b0;
            end else begin
                wait_left--;
                wb_ack = 1'b0;
            end
        end else begin
            wb_ack   = 1'b0;
            in_cycle = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    initial begin
        int   i;
        int   limit;
        int   cycles;
        logic timed_out;
        logic setup_failed;
        rst_n        = 1'b0;
        timed_out    = 1'b0;
        setup_failed = 1'b0;
        cycles       = 0;
        // Unknown opcode in every word not loaded from the file
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[8'(i)] = {8'hfc, 16'h0000, 8'(i)};
        end
        $readmemh("bench/core_testdata.hex", mem);
        exp_count = int'(mem[COUNT_WORD]);

        if (exp_count < 1 || exp_count > 32) begin
            $display("Test data holds an unusable store count of %0d", exp_count);
            setup_failed = 1'b1;
        end else begin
            limit = 64 * exp_count + 200;
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            while (store_idx < exp_count && cycles < limit) begin
                @(posedge clk);
                cycles++;
            end
            if (store_idx < exp_count) begin
                $display("Timeout after %0d cycles, the core stopped making progress",
                         cycles);
                timed_out = 1'b1;
            end else begin
                // Core spins from here and late stores still get flagged
                repeat (DRAIN_CYCLES) @(posedge clk);
            end
        end

        $display("Checks %0d, mismatches %0d, other errors %0d, stores seen %0d of %0d",
                 checks, value_errors, other_errors, store_idx, exp_count);
        if (value_errors == 0 && other_errors == 0 && !timed_out && !setup_failed) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* bench/core_testdata.hex */
// Program words from word 0, one instruction per line, then preset data at word 0x60
// Word 0xbf is the expected store count, then one store per line as address and data
@00
24010200  // 00 addiu r1, r0, 0x200
24020005  // 04 addiu r2, r0, 5
2403FFFD  // 08 addiu r3, r0, -3
00432021  // 0c addu  r4, r2, r3
AC240000  // 10 sw    r4, 0(r1)
00622823  // 14 subu  r5, r3, r2
AC250004  // 18 sw    r5, 4(r1)
3C061234  // 1c lui   r6, 0x1234
24C65678  // 20 addiu r6, r6, 0x5678
AC260008  // 24 sw    r6, 8(r1)
24070FF0  // 28 addiu r7, r0, 0xff0
00C73824  // 2c and   r7, r6, r7
00E24025  // 30 or    r8, r7, r2
AC27000C  // 34 sw    r7, 12(r1)
AC280010  // 38 sw    r8, 16(r1)
0062482A  // 3c slt   r9, r3, r2
0043502A  // 40 slt   r10, r2, r3
AC290014  // 44 sw    r9, 20(r1)
AC2A0018  // 48 sw    r10, 24(r1)
8C0C0180  // 4c lw    r12, 0x180(r0)
8C0D0184  // 50 lw    r13, 0x184(r0)
018D7021  // 54 addu  r14, r12, r13
AC2E001C  // 58 sw    r14, 28(r1)
10420001  // 5c beq   r2, r2, +1, taken
AC220000  // 60 sw    r2, 0(r1), skipped
10430001  // 64 beq   r2, r3, +1, not taken
AC230020  // 68 sw    r3, 32(r1)
14430001  // 6c bne   r2, r3, +1, taken
AC220000  // 70 sw    r2, 0(r1), skipped
14420001  // 74 bne   r2, r2, +1, not taken
AC2C0024  // 78 sw    r12, 36(r1)
240F0003  // 7c addiu r15, r0, 3
24100000  // 80 addiu r16, r0, 0
26100007  // 84 addiu r16, r16, 7
25EFFFFF  // 88 addiu r15, r15, -1
15E0FFFD  // 8c bne   r15, r0, back to 84
AC300028  // 90 sw    r16, 40(r1)
08000028  // 94 j     0xa0
AC220000  // 98 sw    r2, 0(r1), skipped
AC220000  // 9c sw    r2, 0(r1), skipped
AC26002C  // a0 sw    r6, 44(r1)
8C310004  // a4 lw    r17, 4(r1)
00119023  // a8 subu  r18, r0, r17
AC320030  // ac sw    r18, 48(r1)
0800002C  // b0 j     0xb0, spin
@60
00000123  // byte 0x180
FFFFFFF0  // byte 0x184
@bf
0000000D
00000200 00000002
00000204 FFFFFFF8
00000208 12345678
0000020C 00000670
00000210 00000675
00000214 00000001
00000218 00000000
0000021C 00000113
00000220 FFFFFFFD
00000224 00000123
00000228 00000015
0000022C 12345678
00000230 00000008

/* project.f */
+incdir+include
verilog/bus_pkg.sv
verilog/isa_pkg.sv
verilog/bus_arbiter.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/execute_unit.sv
verilog/mips_core.sv
bench/mips_core_assertions.sv
bench/mips_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mips_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mips_core_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmips_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0
